// File: common/accel_pkg.sv
// Accelerator package with shared types, register offsets and the memory contract
package accel_pkg;

   ////////////////////////////////////////////////////
   // Memory port contract
   ////////////////////////////////////////////////////

   localparam int RD_LATENCY = 2; // Read strobe to response, in cycles

   typedef struct packed {
      logic        strobe; // Single-cycle request
      logic        we;
      logic [31:0] addr;
      logic [31:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic        strobe;
      logic [31:0] rdata;
   } mem_rsp_t;

   // Peer side, held until granted
   typedef struct packed {
      logic        req;
      logic        we;
      logic [31:0] addr; // Offset, base is added by the arbiter
      logic [31:0] wdata;
   } peer_req_t;

   ////////////////////////////////////////////////////
   // Job and core types
   ////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      OP_COPY = 2'd0,
      OP_ADD  = 2'd1,
      OP_XOR  = 2'd2,
      OP_NOT  = 2'd3
   } op_e;

   typedef struct packed {
      logic [31:0] src;
      logic [31:0] dst;
      logic [15:0] len;
      op_e         op;
      logic [31:0] operand;
   } job_t;

   typedef enum logic [1:0] {
      CS_IDLE  = 2'd0,
      CS_RUN   = 2'd1, // Reads still to issue
      CS_DRAIN = 2'd2  // Waiting on the last writes
   } core_state_e;

   // APB register map
   typedef enum logic [7:0] {
      REG_BASE    = 8'h00,
      REG_STATUS  = 8'h04, // RO, bit 0 busy
      REG_SRESET  = 8'h08,
      REG_SRC     = 8'h0C,
      REG_DST     = 8'h10,
      REG_LEN     = 8'h14,
      REG_OP      = 8'h18,
      REG_OPERAND = 8'h1C,
      REG_START   = 8'h20  // WO, pulse
   } reg_e;

endpackage

// File: design/ctrl_regs.sv
// Control registers: APB slave with job settings, soft-reset sequencer and start strobe
`timescale 1ns/100ps

module ctrl_regs #(
   parameter int RESET_CYCLES = 8
) (
   input  logic               clk,
   input  logic               vx_reset_started,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [31:0]        paddr,
   input  logic [31:0]        pwdata,
   input  logic               busy,
   output logic [31:0]        prdata,
   output logic               pready,
   output accel_pkg::job_t    job,
   output logic [31:0]        base,
   output logic               start,
   output logic               core_reset
);

   localparam int CW = $clog2(RESET_CYCLES + 1);

   logic              apb_write;
   logic              apb_read;
   accel_pkg::reg_e   reg_sel;
   logic              sreset_q; // Soft reset in progress, also the readback bit
   logic [CW-1:0]     sreset_cnt;

   assign apb_write = psel & penable & pwrite; // Access phase edge
   assign apb_read  = psel & ~penable & ~pwrite; // Setup phase
   assign reg_sel   = accel_pkg::reg_e'(paddr[7:0]);
   assign pready    = 1'b1;

   ////////////////////////////////////////////////////
   // Register writes and readback
   ////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (vx_reset_started) begin
         base   <= '0;
         job    <= '0;
         prdata <= '0;
         start  <= 1'b0;
      end else begin
         start <= apb_write && (reg_sel == accel_pkg::REG_START);
         if (apb_write) begin
            case (reg_sel)
               accel_pkg::REG_BASE:    base        <= pwdata;
               accel_pkg::REG_SRC:     job.src     <= pwdata;
               accel_pkg::REG_DST:     job.dst     <= pwdata;
               accel_pkg::REG_LEN:     job.len     <= pwdata[15:0];
               accel_pkg::REG_OP:      job.op      <= accel_pkg::op_e'(pwdata[1:0]);
               accel_pkg::REG_OPERAND: job.operand <= pwdata;
               default: ;
            endcase
         end
         if (apb_read) begin
            case (reg_sel)
               accel_pkg::REG_BASE:    prdata <= base;
               accel_pkg::REG_STATUS:  prdata <= {31'b0, busy};
               accel_pkg::REG_SRESET:  prdata <= {31'b0, sreset_q};
               accel_pkg::REG_SRC:     prdata <= job.src;
               accel_pkg::REG_DST:     prdata <= job.dst;
               accel_pkg::REG_LEN:     prdata <= {16'b0, job.len};
               accel_pkg::REG_OP:      prdata <= {30'b0, job.op};
               accel_pkg::REG_OPERAND: prdata <= job.operand;
               default:                prdata <= '0;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////
   // Soft reset sequencer
   ////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (vx_reset_started) begin
         sreset_q   <= 1'b0;
         sreset_cnt <= '0;
      end else if (apb_write && reg_sel == accel_pkg::REG_SRESET && pwdata[0] && !sreset_q) begin
         sreset_q   <= 1'b1; // Core held from the next cycle
         sreset_cnt <= '0;
      end else if (sreset_q) begin
         if (sreset_cnt == CW'(RESET_CYCLES - 1))
            sreset_q <= 1'b0; // Self clearing
         sreset_cnt <= sreset_cnt + 1'b1;
      end
   end

   assign core_reset = vx_reset_started | sreset_q;

endmodule

// File: design/mem_arbiter.sv
// Memory arbiter: round-robin between load and store peers, adds the base offset
`timescale 1ns/100ps

module mem_arbiter (
   input  logic                  clk,
   input  logic                  vx_reset_started,
   input  logic [31:0]           base,
   input  accel_pkg::peer_req_t  ld_req,
   input  accel_pkg::peer_req_t  st_req,
   output logic                  ld_grant,
   output logic                  st_grant,
   output accel_pkg::mem_req_t   mem_req
);

   logic                  last_st; // Store peer won the last grant
   accel_pkg::peer_req_t  winner;

   ////////////////////////////////////////////////////
   // Grant, same cycle as the request
   ////////////////////////////////////////////////////

   // Priority flips to the peer that did not win last
   assign ld_grant = ld_req.req & (~st_req.req | last_st);
   assign st_grant = st_req.req & (~ld_req.req | ~last_st);

   always_ff @(posedge clk) begin
      if (vx_reset_started)
         last_st <= 1'b0;
      else if (ld_grant | st_grant)
         last_st <= st_grant;
   end

   ////////////////////////////////////////////////////
   // Memory request
   ////////////////////////////////////////////////////

   assign winner = st_grant ? st_req : ld_req;

   always_comb begin
      mem_req.strobe = ld_grant | st_grant;
      mem_req.we     = winner.we;
      mem_req.addr   = base + winner.addr; // Relocate into the host window
      mem_req.wdata  = winner.wdata;
   end

   // One owner of the memory port per cycle
   a_one_grant : assert property (@(posedge clk) disable iff (vx_reset_started)
      !(ld_grant && st_grant));

endmodule

// File: design/stream_core/load_unit.sv
// Load unit: issues source reads and buffers the responses in a FIFO
`timescale 1ns/100ps

module load_unit #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  core_reset,
   input  logic                  go,
   input  logic [31:0]           src,
   input  logic [15:0]           len,
   input  logic                  grant,
   input  accel_pkg::mem_rsp_t   rsp,
   input  logic                  pop,
   output accel_pkg::peer_req_t  req,
   output logic [31:0]           rdata,
   output logic                  avail,
   output logic                  all_issued
);

   localparam int AW = $clog2(FIFO_DEPTH);

   logic [31:0]    fifo_mem [FIFO_DEPTH];
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [AW:0]    fill;
   logic [AW:0]    outstanding; // Reads granted, no response yet
   logic [AW+1:0]  credit_used;
   logic [15:0]    rd_idx;

   assign credit_used = outstanding + fill;
   assign all_issued  = (rd_idx == len);
   assign avail       = (fill != '0);
   assign rdata       = fifo_mem[rd_ptr];

   always_comb begin
      req.req   = !all_issued && (credit_used < FIFO_DEPTH); // Never overrun the FIFO
      req.we    = 1'b0;
      req.addr  = src + {16'b0, rd_idx};
      req.wdata = '0;
   end

   always_ff @(posedge clk) begin
      if (core_reset) begin
         rd_idx      <= '0;
         outstanding <= '0;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         fill        <= '0;
      end else begin
         if (go)
            rd_idx <= '0;
         else if (grant)
            rd_idx <= rd_idx + 16'd1;
         outstanding <= outstanding + (grant ? 1'b1 : 1'b0) - (rsp.strobe ? 1'b1 : 1'b0);
         fill        <= fill + (rsp.strobe ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
         if (rsp.strobe) wr_ptr <= wr_ptr + 1'b1;
         if (pop)        rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rsp.strobe)
         fifo_mem[wr_ptr] <= rsp.rdata;
   end

   a_no_overflow : assert property (@(posedge clk) disable iff (core_reset)
      rsp.strobe |-> (fill != FIFO_DEPTH));

   // Response only for a read granted at the fixed latency
   a_rsp_timing : assert property (@(posedge clk) disable iff (core_reset)
      rsp.strobe |-> $past(grant, accel_pkg::RD_LATENCY));

endmodule

// File: design/stream_core/store_unit.sv
// Store unit: holds one transformed word and writes it to the destination
`timescale 1ns/100ps

module store_unit (
   input  logic                  clk,
   input  logic                  core_reset,
   input  logic                  go,
   input  logic [31:0]           dst,
   input  logic [15:0]           len,
   input  logic [31:0]           wdata,
   input  logic                  wvalid,
   input  logic                  grant,
   output accel_pkg::peer_req_t  req,
   output logic                  ready,
   output logic                  done
);

   logic         full;   // Holding slot occupied
   logic [31:0]  slot_data;
   logic [15:0]  wr_idx;

   assign ready = ~full;
   assign done  = grant && (wr_idx == len - 16'd1); // Last word of the job

   ////////////////////////////////////////////////////
   // Holding slot
   ////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (core_reset)
         full <= 1'b0;
      else if (wvalid && ready)
         full <= 1'b1;
      else if (grant)
         full <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (wvalid && ready)
         slot_data <= wdata;
   end

   // Write index, restarts on each job
   always_ff @(posedge clk) begin
      if (core_reset)
         wr_idx <= '0;
      else if (go)
         wr_idx <= '0;
      else if (grant)
         wr_idx <= wr_idx + 16'd1;
   end

   always_comb begin
      req.req   = full; // Held until granted
      req.we    = 1'b1;
      req.addr  = dst + {16'b0, wr_idx};
      req.wdata = slot_data;
   end

endmodule

// File: design/stream_core/stream_core.sv
// Stream core: job FSM and word transform between the load and store units
`timescale 1ns/100ps

module stream_core #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  core_reset,
   input  accel_pkg::job_t       job,
   input  logic                  start,
   input  logic                  ld_grant,
   input  logic                  st_grant,
   input  accel_pkg::mem_rsp_t   mem_rsp,
   output accel_pkg::peer_req_t  ld_req,
   output accel_pkg::peer_req_t  st_req,
   output logic                  busy
);

   accel_pkg::core_state_e  state;
   accel_pkg::job_t         job_q; // Snapshot taken at go
   logic                    go;
   logic                    all_issued;
   logic                    st_done;
   logic [31:0]             ld_data;
   logic                    ld_avail;
   logic                    ld_pop;
   logic                    st_ready;
   logic                    xf_valid;
   logic [31:0]             xf_data;

   assign go   = start && (state == accel_pkg::CS_IDLE) && (job.len != 16'd0);
   assign busy = (state != accel_pkg::CS_IDLE);

   ////////////////////////////////////////////////////
   // Job FSM
   ////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (core_reset) begin
         state <= accel_pkg::CS_IDLE;
         job_q <= '0;
      end else begin
         case (state)
            accel_pkg::CS_IDLE:  if (go) begin
               state <= accel_pkg::CS_RUN;
               job_q <= job;
            end
            accel_pkg::CS_RUN:   if (all_issued) state <= accel_pkg::CS_DRAIN;
            accel_pkg::CS_DRAIN: if (st_done) state <= accel_pkg::CS_IDLE; // Last write granted
            default:             state <= accel_pkg::CS_IDLE;
         endcase
      end
   end

   // Transform register, pops only when it can hand off
   assign ld_pop = ld_avail & (~xf_valid | st_ready);

   always_ff @(posedge clk) begin
      if (core_reset) begin
         xf_valid <= 1'b0;
      end else if (ld_pop) begin
         xf_valid <= 1'b1;
      end else if (st_ready) begin
         xf_valid <= 1'b0; // Moved into the store slot
      end
   end

   always_ff @(posedge clk) begin
      if (ld_pop) begin
         case (job_q.op)
            accel_pkg::OP_ADD: xf_data <= ld_data + job_q.operand;
            accel_pkg::OP_XOR: xf_data <= ld_data ^ job_q.operand;
            accel_pkg::OP_NOT: xf_data <= ~ld_data;
            default:           xf_data <= ld_data;
         endcase
      end
   end

   load_unit #(.FIFO_DEPTH(FIFO_DEPTH)) load_unit_i (
      .clk(clk), .core_reset(core_reset), .go(go), .src(job_q.src), .len(job_q.len),
      .grant(ld_grant), .rsp(mem_rsp), .pop(ld_pop),
      .req(ld_req), .rdata(ld_data), .avail(ld_avail), .all_issued(all_issued)
   );

   store_unit store_unit_i (
      .clk(clk), .core_reset(core_reset), .go(go), .dst(job_q.dst), .len(job_q.len),
      .wdata(xf_data), .wvalid(xf_valid), .grant(st_grant),
      .req(st_req), .ready(st_ready), .done(st_done)
   );

   a_start_idle : assert property (@(posedge clk) disable iff (core_reset)
      start |-> (state == accel_pkg::CS_IDLE));

endmodule

// File: design/accel_top.sv
// Accelerator top: APB registers, stream core and memory arbiter on one memory port
`timescale 1ns/100ps

module accel_top #(
   parameter int RESET_CYCLES = 8,
   parameter int FIFO_DEPTH   = 4
) (
   input  logic                 clk,
   input  logic                 vx_reset_started,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [31:0]          paddr,
   input  logic [31:0]          pwdata,
   input  accel_pkg::mem_rsp_t  mem_rsp,
   output logic [31:0]          prdata,
   output logic                 pready,
   output accel_pkg::mem_req_t  mem_req,
   output logic                 busy
);

   accel_pkg::job_t       job;
   logic [31:0]           base;
   logic                  start;
   logic                  core_reset;
   accel_pkg::peer_req_t  ld_req;
   accel_pkg::peer_req_t  st_req;
   logic                  ld_grant;
   logic                  st_grant;

   ////////////////////////////////////////////////////
   // Configuration
   ////////////////////////////////////////////////////

   ctrl_regs #(.RESET_CYCLES(RESET_CYCLES)) ctrl_regs_i (
      .clk              (clk),
      .vx_reset_started (vx_reset_started),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .busy             (busy),
      .prdata           (prdata),
      .pready           (pready),
      .job              (job),
      .base             (base),
      .start            (start),
      .core_reset       (core_reset)
   );

   // Core runs on the soft reset
   stream_core #(.FIFO_DEPTH(FIFO_DEPTH)) stream_core_i (
      .clk        (clk),
      .core_reset (core_reset),
      .job        (job),
      .start      (start),
      .ld_grant   (ld_grant),
      .st_grant   (st_grant),
      .mem_rsp    (mem_rsp),
      .ld_req     (ld_req),
      .st_req     (st_req),
      .busy       (busy)
   );

   mem_arbiter mem_arbiter_i (
      .clk              (clk),
      .vx_reset_started (vx_reset_started),
      .base             (base),
      .ld_req           (ld_req),
      .st_req           (st_req),
      .ld_grant         (ld_grant),
      .st_grant         (st_grant),
      .mem_req          (mem_req)
   );

endmodule

// File: tb/tb_accel.sv
// Accelerator testbench with LFSR driven APB stimulus, a memory model and reference checks
`timescale 1ns/100ps

module tb_accel;

   localparam int RESET_CYCLES = 8;
   localparam int FIFO_DEPTH   = 4;
   localparam int NUM_JOBS     = 20;
   localparam int WATCHDOG_CYCLES = 2000 * (NUM_JOBS + 3); // Extra tests count as jobs

   logic                 clk = 1'b0;
   logic                 vx_reset_started;
   logic                 psel;
   logic                 penable;
   logic                 pwrite;
   logic [31:0]          paddr;
   logic [31:0]          pwdata;
   accel_pkg::mem_rsp_t  mem_rsp = '0;
   logic [31:0]          prdata;
   logic                 pready;
   accel_pkg::mem_req_t  mem_req;
   logic                 busy;

   logic [15:0]  lfsr_q = 16'd47579;
   int           cyc = 0;
   logic [31:0]  mem [logic [31:0]];
   logic [31:0]  rsp_data_q [$];
   int           rsp_due_q [$];

   // Current job as seen by the memory monitor
   logic [31:0]  job_base;
   logic [31:0]  job_src;
   logic [31:0]  job_dst;
   logic [15:0]  job_len = '0; // Zero means no traffic allowed
   logic [31:0]  exp_words [16];
   bit           wr_seen [16];
   bit           rd_seen [16];
   int           wr_count;
   int           rd_count;

   accel_top #(.RESET_CYCLES(RESET_CYCLES), .FIFO_DEPTH(FIFO_DEPTH)) accel_top_i (
      .clk(clk), .vx_reset_started(vx_reset_started), .psel(psel), .penable(penable),
      .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .mem_rsp(mem_rsp),
      .prdata(prdata), .pready(pready), .mem_req(mem_req), .busy(busy)
   );

   always #50 clk = ~clk;

   ////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////

   // Taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [31:0] expected_word(input logic [1:0] op, input logic [31:0] opnd,
                                                 input logic [31:0] w);
      case (op)
         accel_pkg::OP_ADD: return w + opnd;
         accel_pkg::OP_XOR: return w ^ opnd;
         accel_pkg::OP_NOT: return ~w;
         default:           return w;
      endcase
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("test failed");
      $fatal(1, "value mismatch");
   endtask

   task automatic report_error(input string what);
      $display("%s", what);
      $display("test failed");
      $fatal(1, "check failed");
   endtask

   // Setup then access phase and back 10 ns after the access edge
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      #10;
      psel = 1'b1;
      pwrite = 1'b1;
      penable = 1'b0;
      paddr = {24'b0, addr};
      pwdata = data;
      @(posedge clk);
      #10 penable = 1'b1;
      assert (pready === 1'b1) else report_value("pready", {31'b0, pready}, 32'h1);
      @(posedge clk);
      #10;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                           output int setup_cyc);
      @(posedge clk);
      #10;
      psel = 1'b1;
      pwrite = 1'b0;
      penable = 1'b0;
      paddr = {24'b0, addr};
      @(posedge clk);
      #10;
      setup_cyc = cyc;
      penable = 1'b1;
      data = prdata; // Registered at the setup edge
      assert (pready === 1'b1) else report_value("pready", {31'b0, pready}, 32'h1);
      @(posedge clk);
      #10;
      psel = 1'b0;
      penable = 1'b0;
   endtask

   ////////////////////////////////////////////////////
   // Memory model
   ////////////////////////////////////////////////////

   // Read data returns RD_LATENCY cycles after the strobe cycle
   always @(posedge clk) begin
      cyc = cyc + 1;
      #10;
      if (rsp_due_q.size() != 0 && rsp_due_q[0] == cyc) begin
         mem_rsp.strobe = 1'b1;
         mem_rsp.rdata  = rsp_data_q.pop_front();
         void'(rsp_due_q.pop_front());
      end else begin
         mem_rsp = '0;
      end
   end

   always @(negedge clk) begin : mem_monitor
      logic [31:0] idx;
      if (!vx_reset_started && mem_req.strobe) begin
         if (mem_req.we) begin
            idx = mem_req.addr - (job_base + job_dst);
            assert (idx < job_len)
               else report_value("mem_req.addr", mem_req.addr, job_base + job_dst);
            assert (!wr_seen[idx]) else report_error("destination word written twice");
            assert (mem_req.wdata == exp_words[idx])
               else report_value("mem_req.wdata", mem_req.wdata, exp_words[idx]);
            wr_seen[idx] = 1'b1;
            wr_count++;
            mem[mem_req.addr] = mem_req.wdata;
         end else begin
            idx = mem_req.addr - (job_base + job_src);
            assert (idx < job_len)
               else report_value("mem_req.addr", mem_req.addr, job_base + job_src);
            assert (!rd_seen[idx]) else report_error("source word read twice in one job");
            rd_seen[idx] = 1'b1;
            rd_count++;
            rsp_data_q.push_back(mem.exists(mem_req.addr) ? mem[mem_req.addr] : 32'h0);
            rsp_due_q.push_back(cyc + accel_pkg::RD_LATENCY);
         end
      end
   end

   ////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////

   task automatic check_readback();
      logic [7:0]  addrs [6];
      logic [31:0] masks [6];
      logic [31:0] vals [6];
      logic [31:0] got;
      int          setup_cyc;
      addrs = '{accel_pkg::REG_BASE, accel_pkg::REG_SRC, accel_pkg::REG_DST,
                accel_pkg::REG_LEN, accel_pkg::REG_OP, accel_pkg::REG_OPERAND};
      masks = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                32'h0000_FFFF, 32'h3, 32'hFFFF_FFFF};
      for (int i = 0; i < 6; i++) begin
         vals[i] = rand_bits(32);
         write_reg(addrs[i], vals[i]);
      end
      for (int i = 0; i < 6; i++) begin
         read_reg(addrs[i], got, setup_cyc);
         assert (got == (vals[i] & masks[i]))
            else report_value("prdata", got, vals[i] & masks[i]);
      end
   endtask

   task automatic check_soft_reset();
      logic [31:0] got;
      logic        exp_bit;
      int          reset_cyc;
      int          setup_cyc;
      int          reads;
      job_len = '0;
      write_reg(accel_pkg::REG_LEN, 32'd5);
      write_reg(accel_pkg::REG_SRESET, 32'd1);
      reset_cyc = cyc;
      write_reg(accel_pkg::REG_START, 32'd1); // Lands while the core is held
      reads = 0;
      do begin
         read_reg(accel_pkg::REG_SRESET, got, setup_cyc);
         exp_bit = (setup_cyc - reset_cyc) <= RESET_CYCLES;
         assert (got == {31'b0, exp_bit}) else report_value("prdata", got, {31'b0, exp_bit});
         assert (busy == 1'b0) else report_value("busy", {31'b0, busy}, 32'h0);
         reads++;
      end while (got[0] && reads < 2 * RESET_CYCLES);
      read_reg(accel_pkg::REG_STATUS, got, setup_cyc);
      assert (got == 32'h0) else report_value("prdata", got, 32'h0);
   endtask

   task automatic check_zero_length();
      job_len = '0;
      write_reg(accel_pkg::REG_LEN, 32'd0);
      write_reg(accel_pkg::REG_START, 32'd1);
      repeat (8) begin
         @(negedge clk);
         assert (busy == 1'b0) else report_error("busy rose for a zero length job");
      end
   endtask

   task automatic run_job();
      logic [31:0] b;
      logic [31:0] s;
      logic [31:0] d;
      logic [31:0] opnd;
      logic [31:0] w;
      logic [1:0]  op;
      logic [15:0] len;
      int          waited;
      b    = rand_bits(32);
      s    = rand_bits(8);
      d    = 32'h400 + rand_bits(8); // Kept clear of the source words
      len  = 16'(1 + rand_bits(4) % 12);
      op   = 2'(rand_bits(2));
      opnd = rand_bits(32);
      for (int i = 0; i < 16; i++) begin
         wr_seen[i] = 1'b0;
         rd_seen[i] = 1'b0;
      end
      for (int i = 0; i < len; i++) begin
         w = rand_bits(32);
         mem[b + s + i] = w;
         exp_words[i] = expected_word(op, opnd, w);
      end
      job_base = b;
      job_src = s;
      job_dst = d;
      job_len = len;
      wr_count = 0;
      rd_count = 0;
      write_reg(accel_pkg::REG_BASE, b);
      write_reg(accel_pkg::REG_SRC, s);
      write_reg(accel_pkg::REG_DST, d);
      write_reg(accel_pkg::REG_LEN, {16'b0, len});
      write_reg(accel_pkg::REG_OP, {30'b0, op});
      write_reg(accel_pkg::REG_OPERAND, opnd);
      write_reg(accel_pkg::REG_START, 32'd1);
      waited = 0;
      while (busy !== 1'b1 && waited < 4) begin
         @(negedge clk);
         waited++;
      end
      assert (busy === 1'b1) else report_error("busy did not rise after start");
      do begin
         @(negedge clk);
         #1;
      end while (busy);
      assert (wr_count == len) else report_value("write count", wr_count, {16'b0, len});
      assert (rd_count == len) else report_value("read count", rd_count, {16'b0, len});
   endtask

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Simulation ran out of time before all jobs completed");
      $display("test failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      vx_reset_started = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      repeat (2) @(posedge clk);
      #10 vx_reset_started = 1'b0;
      check_readback();
      check_soft_reset();
      check_zero_length();
      for (int j = 0; j < NUM_JOBS; j++)
         run_job();
      $display("test passed");
      $finish;
   end

endmodule

// File: src.f
common/accel_pkg.sv
design/ctrl_regs.sv
design/mem_arbiter.sv
design/stream_core/load_unit.sv
design/stream_core/store_unit.sv
design/stream_core/stream_core.sv
design/accel_top.sv
tb/tb_accel.sv

// File: Makefile
TOOL       := verilator
FLAGS      := --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wno-fatal
TOP        := tb_accel
FILELIST   := src.f
BUILD      := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^test passed$$" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
